// ==== bench/fetch_tb.sv ====
// fetch subsystem testbench: program load, scenario table, reference pc model,
// instruction checks and a watchdog

`default_nettype none

module fetch_tb
    import riscv_pkg::*;
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] BOOT_PC     = 32'h0000_0100;
    localparam int unsigned MEM_ADDR_W  = 8;
    localparam int unsigned MEM_LATENCY = 2;
    localparam int unsigned WORDS       = 2**MEM_ADDR_W;
    localparam int unsigned NROWS       = 8;
    localparam logic [31:0] SEED        = 32'h508336a2;
    localparam logic [MEM_ADDR_W-1:0] FAR_BASE = MEM_ADDR_W'(WORDS - 16); // never fetched

    typedef enum logic [2:0] {K_NONE, K_JUMP, K_MEPC, K_TRAP_DIR, K_TRAP_VEC, K_FLUSH} kind_t;

    typedef struct packed {
        int unsigned count;   // instructions to take
        logic [3:0]  density; // stall_i high when rng[3:0] < density
        kind_t       kind;
        logic [31:0] target;  // jump target or mepc
        logic [29:0] base;    // mtvec base
        logic [30:0] code;    // mcause trap code
        int unsigned fire;    // cycle within the row of the redirect or load burst
        logic        load;    // load burst during the row
    } row_t;

    // count, density, kind, target, base, code, fire, load
    localparam row_t ROWS [NROWS] = '{
        '{32'd24, 4'd0,  K_NONE,     32'h0000_0000, 30'h00, 31'd0, 32'd0, 1'b0},
        '{32'd32, 4'd10, K_NONE,     32'h0000_0000, 30'h00, 31'd0, 32'd0, 1'b0},
        '{32'd20, 4'd4,  K_JUMP,     32'h0000_0040, 30'h00, 31'd0, 32'd6, 1'b0},
        '{32'd20, 4'd3,  K_MEPC,     32'h0000_02a0, 30'h00, 31'd0, 32'd5, 1'b0},
        '{32'd20, 4'd5,  K_TRAP_DIR, 32'h0000_0000, 30'h20, 31'd3, 32'd4, 1'b0},
        '{32'd20, 4'd2,  K_TRAP_VEC, 32'h0000_0000, 30'h30, 31'd7, 32'd7, 1'b1},
        '{32'd24, 4'd5,  K_FLUSH,    32'h0000_0000, 30'h00, 31'd0, 32'd6, 1'b1},
        '{32'd40, 4'd6,  K_NONE,     32'h0000_0000, 30'h00, 31'd0, 32'd3, 1'b1}
    };

    logic                  clk, rstn;
    logic                  stall, flush_cache, new_pc_en;
    pc_sel_t               pc_sel;
    logic [31:0]           branch_target, csr_mepc;
    mcause_t               mcause;
    mtvec_t                mtvec;
    logic                  load_en;
    logic [MEM_ADDR_W-1:0] load_addr;
    logic [31:0]           load_data;
    logic                  valid;
    logic [31:0]           instr, pc;

    logic [31:0] shadow [WORDS]; // what the memory holds
    logic [31:0] rng;
    logic [31:0] exp_pc;         // reference architectural pc
    logic        held;           // last sample showed a stalled instruction
    logic [31:0] held_instr, held_pc;
    int unsigned errors, checked;

    fetch_top #(
        .BOOT_PC     (BOOT_PC),
        .MEM_ADDR_W  (MEM_ADDR_W),
        .MEM_LATENCY (MEM_LATENCY)
    ) uut (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .valid_o         (valid),
        .instr_o         (instr),
        .pc_o            (pc),
        .stall_i         (stall),
        .flush_cache_i   (flush_cache),
        .new_pc_en_i     (new_pc_en),
        .pc_sel_i        (pc_sel),
        .branch_target_i (branch_target),
        .csr_mepc_i      (csr_mepc),
        .mcause_i        (mcause),
        .mtvec_i         (mtvec),
        .load_en_i       (load_en),
        .load_addr_i     (load_addr),
        .load_data_i     (load_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // where fetch must resume after a redirect
    function automatic logic [31:0] target_of(input row_t row, input logic [31:0] cur_pc);
        case (row.kind)
            K_JUMP, K_MEPC: return row.target;
            K_TRAP_DIR:     return 32'(row.base) * 32'd4;
            K_TRAP_VEC:     return (32'(row.base) + 32'(row.code)) * 32'd4;
            default:        return cur_pc; // flush keeps pc
        endcase
    endfunction

    function automatic string kind_name(input kind_t k);
        case (k)
            K_JUMP:     return "jump";
            K_MEPC:     return "mret";
            K_TRAP_DIR: return "trap direct";
            K_TRAP_VEC: return "trap vectored";
            K_FLUSH:    return "flush";
            default:    return "sequential";
        endcase
    endfunction

    task automatic fire_redirect(input row_t row);
        new_pc_en     = (row.kind != K_FLUSH);
        flush_cache   = (row.kind == K_FLUSH);
        pc_sel        = (row.kind == K_MEPC) ? PC_MEPC : (row.kind == K_JUMP) ? PC_JUMP : PC_TRAP;
        branch_target = (row.kind == K_JUMP) ? row.target : ~row.target; // wrong pick shows up
        csr_mepc      = (row.kind == K_MEPC) ? row.target : ~row.target;
        mcause        = '{interrupt: 1'b0, trap_code: row.code};
        mtvec         = '{base: row.base, mode: (row.kind == K_TRAP_VEC) ? MTVEC_VECTORED
                                                                          : MTVEC_DIRECT};
    endtask

    // drives the inputs of one cycle 1 ns after the rising edge
    task automatic drive_cycle(input row_t row, input int unsigned cyc, output logic fired);
        logic [MEM_ADDR_W-1:0] idx;
        int unsigned           fire_at;
        rng         = xorshift32(rng);
        stall       = (rng[3:0] < row.density);
        new_pc_en   = 1'b0;
        flush_cache = 1'b0;
        load_en     = 1'b0;
        fired       = 1'b0;
        if (row.load && cyc >= row.fire && cyc < row.fire + 8)
        begin
            rng = xorshift32(rng);
            if (row.kind == K_FLUSH)
            begin
                // rewrite the words ahead of pc while the cpu waits for the flush
                idx   = exp_pc[MEM_ADDR_W+1:2] + MEM_ADDR_W'(cyc - row.fire);
                stall = 1'b1;
            end
            else
                idx = FAR_BASE + MEM_ADDR_W'(cyc - row.fire); // outside the fetched range
            load_en     = 1'b1;
            load_addr   = idx;
            load_data   = rng;
            shadow[idx] = rng;
        end
        fire_at = (row.kind == K_FLUSH && row.load) ? row.fire + 8 : row.fire;
        if (row.kind != K_NONE && cyc == fire_at)
        begin
            fire_redirect(row);
            stall = 1'b1; // nothing taken on the redirect edge
            fired = 1'b1;
        end
    endtask

    // sampled at the falling edge where outputs have settled
    task automatic check_cycle(input int unsigned r, inout int unsigned taken);
        logic [31:0] want;
        if (held)
        begin
            if (!valid)
            begin
                $display("row %0d: valid_o dropped while the instruction was stalled", r);
                errors++;
            end
            else
            begin
                if (instr !== held_instr)
                begin
                    $display("[ERROR] row %0d instr_o got %h expected %h (held)",
                             r, instr, held_instr);
                    errors++;
                end
                if (pc !== held_pc)
                begin
                    $display("[ERROR] row %0d pc_o got %h expected %h (held)",
                             r, pc, held_pc);
                    errors++;
                end
            end
        end
        held = valid && stall;
        held_instr = instr;
        held_pc = pc;
        if (valid && !stall)
        begin
            want = shadow[exp_pc[MEM_ADDR_W+1:2]];
            if (pc !== exp_pc)
            begin
                $display("[ERROR] row %0d pc_o got %h expected %h", r, pc, exp_pc);
                errors++;
            end
            if (instr !== want)
            begin
                $display("[ERROR] row %0d instr_o got %h expected %h", r, instr, want);
                errors++;
            end
            checked++;
            taken++;
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    initial
    begin : main
        row_t        row;
        int unsigned taken, cyc, limit;
        logic        fired;
        rstn          = 1'b0;
        stall         = 1'b0;
        flush_cache   = 1'b0;
        new_pc_en     = 1'b0;
        pc_sel        = PC_JUMP;
        branch_target = '0;
        csr_mepc      = '0;
        mcause        = '0;
        mtvec         = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        rng           = SEED;
        exp_pc        = BOOT_PC;
        held          = 1'b0;
        errors        = 0;
        checked       = 0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        // program load keeps the bus stalled so no fetch sees an unloaded word
        for (int i = 0; i < WORDS; i++)
        begin
            rng       = xorshift32(rng);
            shadow[i] = rng;
            load_en   = 1'b1;
            load_addr = MEM_ADDR_W'(i);
            load_data = rng;
            @(posedge clk);
            #1;
        end
        load_en = 1'b0;
        for (int unsigned r = 0; r < NROWS; r++)
        begin
            row   = ROWS[r];
            taken = 0;
            cyc   = 0;
            limit = row.count * (MEM_LATENCY + 8);
            while ((taken < row.count || cyc <= row.fire + 9) && cyc < limit)
            begin
                drive_cycle(row, cyc, fired);
                @(negedge clk);
                check_cycle(r, taken);
                if (fired)
                begin
                    held   = 1'b0;
                    exp_pc = target_of(row, exp_pc);
                end
                @(posedge clk);
                #1;
                cyc++;
            end
            if (taken < row.count)
            begin
                $display("row %0d: only %0d of %0d instructions arrived", r, taken, row.count);
                errors++;
            end
            $display("row %0d %s: %0d instructions in %0d cycles", r, kind_name(row.kind),
                     taken, cyc);
        end
        $display("%0d rows, %0d instructions checked, %0d errors", NROWS, checked, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // run length from the table plus reset and program load
    initial
    begin : watchdog
        int unsigned cycles;
        cycles = WORDS + 100;
        for (int unsigned r = 0; r < NROWS; r++)
            cycles += ROWS[r].count * (MEM_LATENCY + 8);
        #(cycles * 8);
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/csr_pkg.sv ====
// trap csr types: mtvec with its mode and mcause

`default_nettype none

package csr_pkg;

    // low two bits of mtvec
    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'd0, // every trap goes to base
        MTVEC_VECTORED = 2'd1  // trap goes to base + 4 * cause
    } mtvec_mode_t;

    // base is word aligned, so only the upper 30 bits are stored
    typedef struct packed {
        logic [29:0] base;
        mtvec_mode_t mode;
    } mtvec_t;

    typedef struct packed {
        logic        interrupt; // set for interrupts, clear for exceptions
        logic [30:0] trap_code; // exception or interrupt number
    } mcause_t;

endpackage

`default_nettype wire

// ==== design/fetch_top.sv ====
// fetch subsystem top: prefetcher and instruction memory on one wishbone link

`default_nettype none

module fetch_top
    import riscv_pkg::*;
    import csr_pkg::*;
#(
    parameter logic [31:0] BOOT_PC               = 32'h0000_0100,
    parameter int unsigned INSTR_BUFFER_SIZE_POT = 3, // fifo depth 8
    parameter int unsigned MEM_ADDR_W            = 8, // 256 words
    parameter int unsigned MEM_LATENCY           = 2
) (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    // cpu side
    output logic                   valid_o,
    output logic [31:0]            instr_o,
    output logic [31:0]            pc_o,
    input  wire                    stall_i,
    input  wire                    flush_cache_i,
    // redirect
    input  wire                    new_pc_en_i,
    input  var pc_sel_t            pc_sel_i,
    input  wire  [31:0]            branch_target_i,
    input  wire  [31:0]            csr_mepc_i,
    input  var mcause_t            mcause_i,
    input  var mtvec_t             mtvec_i,
    // program load
    input  wire                    load_en_i,
    input  wire  [MEM_ADDR_W-1:0]  load_addr_i,
    input  wire  [31:0]            load_data_i
);

    wb_req_t wb_req; // prefetcher to memory
    wb_rsp_t wb_rsp; // memory to prefetcher

    wb_prefetch #(
        .BOOT_PC               (BOOT_PC),
        .INSTR_BUFFER_SIZE_POT (INSTR_BUFFER_SIZE_POT)
    ) u_prefetch (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .wb_req_o        (wb_req),
        .wb_rsp_i        (wb_rsp),
        .valid_o         (valid_o),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .stall_i         (stall_i),
        .flush_cache_i   (flush_cache_i),
        .new_pc_en_i     (new_pc_en_i),
        .pc_sel_i        (pc_sel_i),
        .branch_target_i (branch_target_i),
        .csr_mepc_i      (csr_mepc_i),
        .mcause_i        (mcause_i),
        .mtvec_i         (mtvec_i)
    );

    wb_instr_mem #(
        .MEM_ADDR_W  (MEM_ADDR_W),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_instr_mem (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

endmodule

`default_nettype wire

// ==== design/riscv_pkg.sv ====
// fetch side types: redirect source select and the
// pipelined wishbone request/response bundles

`default_nettype none

package riscv_pkg;

    // where the next pc comes from on a redirect
    typedef enum logic [1:0] {
        PC_JUMP = 2'd0, // jump or taken branch
        PC_MEPC = 2'd1, // mret, back to the interrupted instruction
        PC_TRAP = 2'd2  // exception or interrupt entry through mtvec
    } pc_sel_t;

    // master to slave
    // read-only master, so no write data travels here
    typedef struct packed {
        logic        cyc;  // bus cycle in progress
        logic        stb;  // request strobe
        logic        we;   // always low for fetch
        logic [3:0]  sel;  // byte lanes
        logic [31:0] addr; // byte address
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        stall; // request not taken this cycle
        logic        ack;   // one per accepted request, in order
        logic [31:0] rdata; // read word, qualified by ack
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== design/sync_fifo.sv ====
// synchronous power-of-two fifo with clear, full/empty flags and fill count

`default_nettype none

module sync_fifo #(
    parameter int unsigned BW                    = 32,
    parameter int unsigned INSTR_BUFFER_SIZE_POT = 3  // log2 of the depth
) (
    input  wire                             clk_i,
    input  wire                             rstn_i,
    input  wire                             clear_i,      // drop everything, wins over wr/rd
    input  wire                             wr_i,
    input  wire  [BW-1:0]                   data_i,
    input  wire                             rd_i,
    output logic [BW-1:0]                   data_o,       // word at the read pointer
    output logic                            full_o,
    output logic                            empty_o,
    output logic [INSTR_BUFFER_SIZE_POT:0]  fill_count_o
);

    localparam int unsigned DEPTH = 2**INSTR_BUFFER_SIZE_POT;

    logic [BW-1:0] mem [DEPTH];

    // one extra bit tells a full buffer from an empty one
    logic [INSTR_BUFFER_SIZE_POT:0] wr_ptr_q;
    logic [INSTR_BUFFER_SIZE_POT:0] rd_ptr_q;
    logic                           do_wr;
    logic                           do_rd;

    assign fill_count_o = wr_ptr_q - rd_ptr_q;
    assign empty_o      = (wr_ptr_q == rd_ptr_q);
    assign full_o       = fill_count_o[INSTR_BUFFER_SIZE_POT]; // count never exceeds DEPTH

    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    // read side is a plain mux, the word is visible in the same cycle
    assign data_o = mem[rd_ptr_q[INSTR_BUFFER_SIZE_POT-1:0]];

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i || clear_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_rd)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk_i)
    begin
        if (do_wr)
            mem[wr_ptr_q[INSTR_BUFFER_SIZE_POT-1:0]] <= data_i;
    end

endmodule

`default_nettype wire

// ==== design/wb_instr_mem.sv ====
// pipelined wishbone instruction memory with fixed read latency
// and a load port that takes the array and stalls the bus

`default_nettype none

module wb_instr_mem
    import riscv_pkg::*;
#(
    parameter int unsigned MEM_ADDR_W  = 8, // word address bits
    parameter int unsigned MEM_LATENCY = 2  // accept edge to ack edge, at least 1
) (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  var wb_req_t            wb_req_i,
    output wb_rsp_t                wb_rsp_o,
    input  wire                    load_en_i,   // program load, wins over the bus
    input  wire  [MEM_ADDR_W-1:0]  load_addr_i, // word address
    input  wire  [31:0]            load_data_i
);

    localparam int unsigned WORDS = 2**MEM_ADDR_W;

    logic [31:0]            mem [WORDS];
    logic                   accept;
    logic [MEM_ADDR_W-1:0]  rd_addr;

    // response chain, stage 0 is loaded at the accept edge
    logic [MEM_LATENCY-1:0] vld_q;
    logic [31:0]            data_q [MEM_LATENCY];

    assign accept  = wb_req_i.cyc && wb_req_i.stb && !load_en_i;
    assign rd_addr = wb_req_i.addr[MEM_ADDR_W+1:2]; // byte address to word index

    // single array port: a load cycle stalls any request
    always_ff @(posedge clk_i)
    begin
        if (load_en_i)
            mem[load_addr_i] <= load_data_i;
    end

    // valid bits carry the acks
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
            vld_q <= '0;
        else
        begin
            vld_q[0] <= accept;
            for (int i = 1; i < MEM_LATENCY; i++)
                vld_q[i] <= vld_q[i-1];
        end
    end

    // data moves along with its valid bit
    always_ff @(posedge clk_i)
    begin
        if (accept)
            data_q[0] <= mem[rd_addr]; // word as it stands at acceptance
        for (int i = 1; i < MEM_LATENCY; i++)
            data_q[i] <= data_q[i-1];
    end

    assign wb_rsp_o = '{
        stall: load_en_i,
        ack:   vld_q[MEM_LATENCY-1],
        rdata: data_q[MEM_LATENCY-1]
    };

endmodule

`default_nettype wire

// ==== design/wb_prefetch.sv ====
// pipelined wishbone read master with redirect target select,
// stale ack bookkeeping and the instruction fifo towards the cpu

`default_nettype none

module wb_prefetch
    import riscv_pkg::*;
    import csr_pkg::*;
#(
    parameter logic [31:0] BOOT_PC               = 32'h0000_0000,
    parameter int unsigned INSTR_BUFFER_SIZE_POT = 3
) (
    input  wire          clk_i,
    input  wire          rstn_i,
    // wishbone
    output wb_req_t      wb_req_o,
    input  var wb_rsp_t  wb_rsp_i,
    // cpu side
    output logic         valid_o,         // instr_o/pc_o hold an instruction
    output logic [31:0]  instr_o,
    output logic [31:0]  pc_o,            // pc of the presented instruction
    input  wire          stall_i,         // cpu does not take the instruction
    input  wire          flush_cache_i,   // refetch from pc_o
    // redirect
    input  wire          new_pc_en_i,
    input  var pc_sel_t  pc_sel_i,
    input  wire  [31:0]  branch_target_i,
    input  wire  [31:0]  csr_mepc_i,
    input  var mcause_t  mcause_i,
    input  var mtvec_t   mtvec_i
);

    localparam int unsigned CW = INSTR_BUFFER_SIZE_POT + 1; // counter width

    // fifo depth two bits wider than the pot so the usage sum cannot wrap
    localparam logic [CW:0] BUF_DEPTH = {2'b01, {INSTR_BUFFER_SIZE_POT{1'b0}}};

    typedef enum logic [1:0] {BOOT, REQUESTING, BUFFER_FULL} state_t;

    state_t        state_q, state_d;
    logic          cyc, stb;
    logic          req_ok;                // request taken by the slave this edge
    logic          redirect;              // jump/trap/mret or flush
    logic [31:0]   trap_target;
    logic [31:0]   new_pc;
    logic [31:0]   fetch_pc_q, fetch_pc_d;
    logic [31:0]   arch_pc_q, arch_pc_d;

    // useful acks still expected, and acks of requests made before a redirect
    logic [CW-1:0] req_pending_q, req_pending_d;
    logic [CW-1:0] acks_to_ignore_q, acks_to_ignore_d;
    logic [CW:0]   in_use;                // fifo slots already spoken for

    logic          ff_wr, ff_rd;
    logic          ff_empty;
    logic [CW-1:0] ff_fill_count;
    logic [31:0]   ff_rdata;

    assign req_ok   = cyc && stb && !wb_rsp_i.stall;
    assign redirect = new_pc_en_i || flush_cache_i;
    assign in_use   = {1'b0, req_pending_q} + {1'b0, acks_to_ignore_q} + {1'b0, ff_fill_count};

    // vectored mode adds the cause number in words
    always_comb
    begin
        case (mtvec_i.mode)
            MTVEC_VECTORED: trap_target = {mtvec_i.base + mcause_i.trap_code[29:0], 2'b00};
            default:        trap_target = {mtvec_i.base, 2'b00}; // direct and the reserved modes
        endcase
    end

    always_comb
    begin
        case (pc_sel_i)
            PC_MEPC: new_pc = csr_mepc_i;
            PC_TRAP: new_pc = trap_target;
            default: new_pc = branch_target_i;
        endcase
    end

    // fetch fsm
    always_comb
    begin
        state_d    = state_q;
        fetch_pc_d = fetch_pc_q;
        cyc        = 1'b0;
        stb        = 1'b0;

        case (state_q)
            BOOT:
            begin
                fetch_pc_d = BOOT_PC; // one idle cycle out of reset
                state_d    = REQUESTING;
            end
            REQUESTING:
            begin
                cyc = 1'b1;
                stb = 1'b1;
                if (req_ok)
                begin
                    fetch_pc_d = fetch_pc_q + 32'd4; // a stalled request keeps its address
                    if (in_use + 1'b1 >= BUF_DEPTH)
                        state_d = BUFFER_FULL; // that was the last free slot
                end
            end
            BUFFER_FULL:
            begin
                if (in_use < BUF_DEPTH) // a slot came back through a read, clear or ignored ack
                    state_d = REQUESTING;
            end
            default: state_d = BOOT;
        endcase

        // redirect overrides the address while the slot accounting stays with the fsm
        if (new_pc_en_i)
            fetch_pc_d = new_pc;
        else if (flush_cache_i)
            fetch_pc_d = arch_pc_q;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            state_q    <= BOOT;
            fetch_pc_q <= BOOT_PC;
        end
        else
        begin
            state_q    <= state_d;
            fetch_pc_q <= fetch_pc_d;
        end
    end

    // wishbone has no abort so acks of old requests are counted out
    always_comb
    begin
        req_pending_d    = req_pending_q;
        acks_to_ignore_d = acks_to_ignore_q;

        if (wb_rsp_i.ack)
        begin
            if (acks_to_ignore_q != '0)
                acks_to_ignore_d = acks_to_ignore_q - 1'b1; // stale one is dropped
            else
                req_pending_d = req_pending_q - 1'b1;        // goes into the fifo
        end

        if (req_ok)
            req_pending_d = req_pending_d + 1'b1;

        if (redirect)
        begin
            acks_to_ignore_d = acks_to_ignore_d + req_pending_d; // every request in flight
            req_pending_d    = '0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            req_pending_q    <= '0;
            acks_to_ignore_q <= '0;
        end
        else
        begin
            req_pending_q    <= req_pending_d;
            acks_to_ignore_q <= acks_to_ignore_d;
        end
    end

    assign ff_wr = wb_rsp_i.ack && (acks_to_ignore_q == '0);
    assign ff_rd = valid_o && !stall_i; // instruction taken by the cpu

    sync_fifo #(
        .BW                    (32),
        .INSTR_BUFFER_SIZE_POT (INSTR_BUFFER_SIZE_POT)
    ) u_instr_fifo (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .clear_i      (redirect),       // also drops an ack landing at the redirect edge
        .wr_i         (ff_wr),
        .data_i       (wb_rsp_i.rdata),
        .rd_i         (ff_rd),
        .data_o       (ff_rdata),
        .full_o       (),
        .empty_o      (ff_empty),
        .fill_count_o (ff_fill_count)
    );

    // architectural pc follows what the cpu takes
    always_comb
    begin
        arch_pc_d = arch_pc_q;
        if (new_pc_en_i)
            arch_pc_d = new_pc;
        else if (flush_cache_i)
            arch_pc_d = arch_pc_q; // presented instruction is fetched again
        else if (ff_rd)
            arch_pc_d = arch_pc_q + 32'd4;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
            arch_pc_q <= BOOT_PC;
        else
            arch_pc_q <= arch_pc_d;
    end

    assign valid_o = !ff_empty;
    assign instr_o = ff_rdata;
    assign pc_o    = arch_pc_q;

    assign wb_req_o = '{cyc: cyc, stb: stb, we: 1'b0, sel: 4'hf, addr: fetch_pc_q};

endmodule

`default_nettype wire

// ==== files.f ====
design/riscv_pkg.sv
design/csr_pkg.sv
design/sync_fifo.sv
design/wb_instr_mem.sv
design/wb_prefetch.sv
design/fetch_top.sv
bench/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the fetch testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module fetch_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vfetch_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" <<< "$out"; then
    exit 0
fi
exit 1
